// File: hw/soc_pkg.sv
package soc_pkg;

   ////////////////////////////////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////////////////////////////////
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   // Any bit set is a write, all clear is a read
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [1:0]        slave_idx_t;

   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } bus_req_t;

   typedef struct packed {
      logic  ready;
      data_t rdata;
   } bus_rsp_t;

   ////////////////////////////////////////////////////////////////////
   // Address map
   ////////////////////////////////////////////////////////////////////
   localparam int UNMAPPED_BIT = 31;
   localparam int REGION_MSB   = 30;
   localparam int REGION_LSB   = 29;
   localparam int WORD_LSB     = 2;

   localparam slave_idx_t REGION_BOOT    = 2'd0;
   localparam slave_idx_t REGION_RAM     = 2'd1;
   localparam slave_idx_t REGION_UART    = 2'd2;
   localparam slave_idx_t REGION_SYSCTRL = 2'd3;

   localparam addr_t SOFT_RESET_ADDR = 32'h6fff_fffc;

   // Sixteen words in both ROM and RAM
   localparam int MEM_WORDS_W = 4;
   localparam int MEM_WORDS   = 1 << MEM_WORDS_W;
   typedef logic [MEM_WORDS_W-1:0] word_idx_t;
   localparam string ROM_FILE = "hw/boot_rom.hex";

   ////////////////////////////////////////////////////////////////////
   // Timing
   ////////////////////////////////////////////////////////////////////
   localparam int POR_W             = 5;
   localparam int SOFT_RESET_CYCLES = 5;
   localparam int SOFT_CNT_W        = $clog2(SOFT_RESET_CYCLES + 1);
   localparam int BAUD_DIV          = 8;
   localparam int BAUD_W            = $clog2(BAUD_DIV);

   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA,
      STOP
   } uart_state_t;

endpackage

// File: hw/reset_ctrl.sv
`timescale 1ns/1ns

module reset_ctrl (
   input  logic              clk,
   input  logic              reset,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output logic              sys_ready,
   output logic              sys_reset,
   output logic              core_reset,
   output logic              mem_sel
);
   import soc_pkg::*;

   logic [POR_W-1:0]      por_cnt;
   logic [SOFT_CNT_W-1:0] soft_cnt;
   logic                  rsp_ready;
   data_t                 rsp_rdata;
   logic                  start;
   logic                  is_soft;

   ////////////////////////////////////////////////////////////////////
   // Power-on counter
   ////////////////////////////////////////////////////////////////////
   // Stops once the top bit sets
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         por_cnt <= '0;
      end else if (!por_cnt[POR_W-1]) begin
         por_cnt <= por_cnt + 1'b1;
      end
   end

   assign sys_ready = por_cnt[POR_W-1];
   // Slaves stay in reset until the count completes
   assign sys_reset = ~sys_ready;

   ////////////////////////////////////////////////////////////////////
   // System-control slave and soft reset
   ////////////////////////////////////////////////////////////////////
   assign start   = req.valid && !rsp_ready && sys_ready;
   assign is_soft = (req.addr == SOFT_RESET_ADDR);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rsp_ready <= 1'b0;
         mem_sel   <= 1'b0;
         soft_cnt  <= '0;
      end else begin
         rsp_ready <= start;
         // Accepted soft-reset access, sticky remap plus core pulse
         if (rsp_ready && req.valid && is_soft) begin
            mem_sel  <= 1'b1;
            soft_cnt <= SOFT_CNT_W'(SOFT_RESET_CYCLES);
         end else if (soft_cnt != '0) begin
            soft_cnt <= soft_cnt - 1'b1;
         end
      end
   end

   // Soft-reset address and writes read back zero
   always_ff @(posedge clk) begin
      if (start) begin
         rsp_rdata <= (is_soft || req.wstrb != '0) ? '0 : data_t'(mem_sel);
      end
   end

   assign core_reset = (soft_cnt != '0);
   assign rsp        = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

// File: hw/bus_interconnect.sv
`timescale 1ns/1ns

module bus_interconnect (
   input  logic              clk,
   input  logic              reset,
   input  logic              mem_sel,
   input  soc_pkg::bus_req_t m_req,
   input  soc_pkg::bus_rsp_t rom_rsp,
   input  soc_pkg::bus_rsp_t ram_rsp,
   input  soc_pkg::bus_rsp_t uart_rsp,
   input  soc_pkg::bus_rsp_t ctrl_rsp,
   output soc_pkg::bus_rsp_t m_rsp,
   output soc_pkg::bus_req_t rom_req,
   output soc_pkg::bus_req_t ram_req,
   output soc_pkg::bus_req_t uart_req,
   output soc_pkg::bus_req_t ctrl_req
);
   import soc_pkg::*;

   slave_idx_t region;
   logic       unmapped;
   logic       sel_rom;
   logic       sel_ram;
   logic       sel_uart;
   logic       sel_ctrl;
   logic       umap_ready;

   ////////////////////////////////////////////////////////////////////
   // Region decode
   ////////////////////////////////////////////////////////////////////
   assign region   = m_req.addr[REGION_MSB:REGION_LSB];
   assign unmapped = m_req.addr[UNMAPPED_BIT];

   // Region 0 follows the boot remap
   assign sel_rom  = !unmapped && (region == REGION_BOOT) && !mem_sel;
   assign sel_ram  = !unmapped && ((region == REGION_RAM) ||
                                   ((region == REGION_BOOT) && mem_sel));
   assign sel_uart = !unmapped && (region == REGION_UART);
   assign sel_ctrl = !unmapped && (region == REGION_SYSCTRL);

   // Same payload everywhere, only valid is steered
   always_comb begin
      rom_req        = m_req;
      ram_req        = m_req;
      uart_req       = m_req;
      ctrl_req       = m_req;
      rom_req.valid  = m_req.valid && sel_rom;
      ram_req.valid  = m_req.valid && sel_ram;
      uart_req.valid = m_req.valid && sel_uart;
      ctrl_req.valid = m_req.valid && sel_ctrl;
   end

   ////////////////////////////////////////////////////////////////////
   // Unmapped responder
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         umap_ready <= 1'b0;
      end else begin
         umap_ready <= m_req.valid && unmapped && !umap_ready;
      end
   end

   // Response back to the master
   always_comb begin
      if (unmapped) begin
         m_rsp = '{ready: umap_ready, rdata: '0};
      end else begin
         case (region)
            REGION_BOOT: m_rsp = mem_sel ? ram_rsp : rom_rsp;
            REGION_RAM:  m_rsp = ram_rsp;
            REGION_UART: m_rsp = uart_rsp;
            default:     m_rsp = ctrl_rsp;
         endcase
      end
   end

endmodule

// File: hw/boot_rom.sv
`timescale 1ns/1ns

module boot_rom (
   input  logic              clk,
   input  logic              reset,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp
);
   import soc_pkg::*;

   data_t     rom [MEM_WORDS];
   word_idx_t idx;
   logic      start;
   logic      rsp_ready;
   data_t     rsp_rdata;

   // Boot image
   initial $readmemh(ROM_FILE, rom);

   assign idx   = req.addr[WORD_LSB +: MEM_WORDS_W];
   assign start = req.valid && !rsp_ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rsp_ready <= 1'b0;
      end else begin
         rsp_ready <= start;
      end
   end

   // Writes acked with zero data, contents untouched
   always_ff @(posedge clk) begin
      if (start) begin
         rsp_rdata <= (req.wstrb != '0) ? '0 : rom[idx];
      end
   end

   assign rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

// File: hw/sram.sv
`timescale 1ns/1ns

module sram (
   input  logic              clk,
   input  logic              reset,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp
);
   import soc_pkg::*;

   data_t     mem [MEM_WORDS];
   word_idx_t idx;
   logic      start;
   logic      is_write;
   logic      rsp_ready;
   data_t     rsp_rdata;

   assign idx      = req.addr[WORD_LSB +: MEM_WORDS_W];
   assign start    = req.valid && !rsp_ready;
   assign is_write = (req.wstrb != '0);

   // One-cycle ack
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rsp_ready <= 1'b0;
      end else begin
         rsp_ready <= start;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////////////
   // Byte lanes written only where the strobe is set
   always_ff @(posedge clk) begin
      if (start && is_write) begin
         for (int lane = 0; lane < STRB_W; lane++) begin
            if (req.wstrb[lane]) begin
               mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
            end
         end
      end
   end

   // Read data, zero on writes
   always_ff @(posedge clk) begin
      if (start) begin
         rsp_rdata <= is_write ? '0 : mem[idx];
      end
   end

   assign rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
   input  logic              clk,
   input  logic              reset,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output logic              ser_tx
);
   import soc_pkg::*;

   uart_state_t       state;
   logic [BAUD_W-1:0] baud_cnt;
   logic [2:0]        bit_cnt;
   logic [2:0]        next_bit;
   logic [7:0]        tx_data;
   logic              baud_tick;
   logic              busy;
   logic              is_status;
   logic              is_write;
   logic              data_wr;
   logic              start;
   logic              rsp_ready;
   data_t             rsp_rdata;

   ////////////////////////////////////////////////////////////////////
   // Register interface
   ////////////////////////////////////////////////////////////////////
   // Offset 0 data, offset 4 status
   assign is_status = req.addr[2];
   assign is_write  = (req.wstrb != '0);
   assign data_wr   = is_write && !is_status;
   assign busy      = (state != IDLE);

   // Data writes stall until the frame in flight is done
   assign start = req.valid && !rsp_ready && (!data_wr || !busy);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rsp_ready <= 1'b0;
      end else begin
         rsp_ready <= start;
      end
   end

   // Only a status read returns anything
   always_ff @(posedge clk) begin
      if (start) begin
         rsp_rdata <= (is_status && !is_write) ? data_t'(busy) : '0;
      end
   end

   assign rsp = '{ready: rsp_ready, rdata: rsp_rdata};

   ////////////////////////////////////////////////////////////////////
   // Transmit FSM
   ////////////////////////////////////////////////////////////////////
   assign baud_tick = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
   assign next_bit  = bit_cnt + 1'b1;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         ser_tx   <= 1'b1;
      end else begin
         // Free-running bit timer, restarted per frame
         baud_cnt <= baud_tick ? '0 : baud_cnt + 1'b1;
         case (state)
            IDLE: begin
               // Byte taken on the accepting ready edge
               if (rsp_ready && req.valid && data_wr) begin
                  state    <= START;
                  baud_cnt <= '0;
                  ser_tx   <= 1'b0;
               end
            end
            START: begin
               if (baud_tick) begin
                  state   <= DATA;
                  bit_cnt <= '0;
                  ser_tx  <= tx_data[0];
               end
            end
            DATA: begin
               if (baud_tick) begin
                  if (bit_cnt == 3'd7) begin
                     state  <= STOP;
                     ser_tx <= 1'b1;
                  end else begin
                     bit_cnt <= next_bit;
                     ser_tx  <= tx_data[next_bit];
                  end
               end
            end
            default: begin
               // Stop bit, line already high
               if (baud_tick) begin
                  state <= IDLE;
               end
            end
         endcase
      end
   end

   // Frame byte, LSB first
   always_ff @(posedge clk) begin
      if (state == IDLE && rsp_ready && req.valid && data_wr) begin
         tx_data <= req.wdata[7:0];
      end
   end

endmodule

// File: hw/soc_top.sv
`timescale 1ns/1ns

module soc_top (
   input  logic              clk,
   input  logic              reset,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output logic              ser_tx,
   output logic              sys_ready,
   output logic              core_reset,
   output logic              mem_sel
);
   import soc_pkg::*;

   logic     sys_reset;
   bus_req_t rom_req;
   bus_req_t ram_req;
   bus_req_t uart_req;
   bus_req_t ctrl_req;
   bus_rsp_t rom_rsp;
   bus_rsp_t ram_rsp;
   bus_rsp_t uart_rsp;
   bus_rsp_t ctrl_rsp;

   ////////////////////////////////////////////////////////////////////
   // Reset and system control
   ////////////////////////////////////////////////////////////////////
   reset_ctrl u_reset_ctrl (
      .clk        (clk),
      .reset      (reset),
      .req        (ctrl_req),
      .rsp        (ctrl_rsp),
      .sys_ready  (sys_ready),
      .sys_reset  (sys_reset),
      .core_reset (core_reset),
      .mem_sel    (mem_sel)
   );

   // Held with the slaves until power-on completes
   bus_interconnect u_bus_interconnect (
      .clk      (clk),
      .reset    (sys_reset),
      .mem_sel  (mem_sel),
      .m_req    (req),
      .rom_rsp  (rom_rsp),
      .ram_rsp  (ram_rsp),
      .uart_rsp (uart_rsp),
      .ctrl_rsp (ctrl_rsp),
      .m_rsp    (rsp),
      .rom_req  (rom_req),
      .ram_req  (ram_req),
      .uart_req (uart_req),
      .ctrl_req (ctrl_req)
   );

   ////////////////////////////////////////////////////////////////////
   // Slaves
   ////////////////////////////////////////////////////////////////////
   boot_rom u_boot_rom (
      .clk   (clk),
      .reset (sys_reset),
      .req   (rom_req),
      .rsp   (rom_rsp)
   );

   sram u_sram (
      .clk   (clk),
      .reset (sys_reset),
      .req   (ram_req),
      .rsp   (ram_rsp)
   );

   uart_tx u_uart_tx (
      .clk    (clk),
      .reset  (sys_reset),
      .req    (uart_req),
      .rsp    (uart_rsp),
      .ser_tx (ser_tx)
   );

endmodule

// File: verification/soc_tb.sv
`timescale 1ns/1ns

module soc_tb;
   import soc_pkg::*;

   localparam int CLK_HALF     = 10;
   localparam int RESET_CYCLES = 3;
   localparam int POR_CYCLES   = 16;
   localparam int BUS_TIMEOUT  = 200;
   localparam int FRAME_BITS   = 10;
   localparam int LINE_TIMEOUT = 4 * FRAME_BITS * BAUD_DIV;

   typedef enum logic [2:0] {
      OP_READ,
      OP_READ_MEM,
      OP_WRITE,
      OP_SOFT,
      OP_SERIAL
   } op_e;

   // One row of the stimulus table
   typedef struct packed {
      op_e   op;
      logic  rnd;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
      data_t exp;
   } entry_t;

   logic       clk;
   logic       reset;
   bus_req_t   req;
   bus_rsp_t   rsp;
   logic       ser_tx;
   logic       sys_ready;
   logic       core_reset;
   logic       mem_sel;

   entry_t     table_q [$];
   string      name_q [$];
   data_t      rom_img [16];
   data_t      ram_shadow [16];
   logic       remapped;
   integer     seed;
   logic [7:0] rx_first;
   logic [7:0] rx_second;
   int         ready_cycle;
   int         cycle_cnt = 0;
   int         core_hi_cnt = 0;
   int         core_first_hi = -1;
   int         test_errors;
   int         tests_run;
   int         tests_failed;
   int         check_errors;

   soc_top DUT (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .rsp        (rsp),
      .ser_tx     (ser_tx),
      .sys_ready  (sys_ready),
      .core_reset (core_reset),
      .mem_sel    (mem_sel)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Rising edges since time zero
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // Width and first cycle of the core reset pulse
   always @(negedge clk) begin
      if (core_reset) begin
         if (core_hi_cnt == 0) begin
            core_first_hi <= cycle_cnt;
         end
         core_hi_cnt <= core_hi_cnt + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Reporting
   ////////////////////////////////////////////////////////////////////
   task automatic abort_run(input string why);
      $display("ERROR: %s", why);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   task automatic check_value(input string name, input data_t exp, input data_t act);
      assert (act === exp) else begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         test_errors++;
      end
   endtask

   task automatic close_test(input string name);
      tests_run++;
      check_errors += test_errors;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("%-18s %s", name, (test_errors == 0) ? "ok" : "failed");
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////////////////////
   // Bus driver, reference models and serial decoder
   ////////////////////////////////////////////////////////////////////
   // One request held until ready and then valid dropped for a cycle
   task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                             output data_t rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      req.valid = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      do begin
         @(negedge clk);
         waited++;
         if (waited > BUS_TIMEOUT) begin
            abort_run("bus request got no ready");
         end
      end while (!rsp.ready);
      rdata       = rsp.rdata;
      ready_cycle = cycle_cnt;
      // Still high at the edge where ready is taken
      @(negedge clk);
      req.valid = 1'b0;
      req.wstrb = '0;
   endtask

   // ROM image before the remap and RAM shadow after it
   function automatic data_t mem_expect(input addr_t addr);
      logic [3:0] idx;
      idx = addr[5:2];
      if (addr[30:29] == 2'd0 && !remapped) begin
         return rom_img[idx];
      end else begin
         return ram_shadow[idx];
      end
   endfunction

   // Byte merge into the shadow for RAM-bound writes only
   task automatic shadow_write(input addr_t addr, input data_t wdata, input strb_t wstrb);
      logic [3:0] idx;
      idx = addr[5:2];
      if (!addr[31] && (addr[30:29] == 2'd1 || (addr[30:29] == 2'd0 && remapped))) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (wstrb[lane]) begin
               ram_shadow[idx][8*lane +: 8] = wdata[8*lane +: 8];
            end
         end
      end
   endtask

   // 8N1 receiver sampling near the middle of each bit
   task automatic serial_receive(output logic [7:0] data);
      int waited;
      waited = 0;
      while (ser_tx) begin
         @(negedge clk);
         waited++;
         if (waited > LINE_TIMEOUT) begin
            abort_run("no start bit seen on ser_tx");
         end
      end
      repeat (BAUD_DIV / 2) @(negedge clk);
      check_value("uart start bit", 32'h0, data_t'(ser_tx));
      for (int i = 0; i < 8; i++) begin
         repeat (BAUD_DIV) @(negedge clk);
         data[i] = ser_tx;
      end
      repeat (BAUD_DIV) @(negedge clk);
      check_value("uart stop bit", 32'h1, data_t'(ser_tx));
   endtask

   task automatic add_entry(input string name, input op_e op, input logic rnd,
                            input addr_t addr, input data_t wdata, input strb_t wstrb,
                            input data_t exp);
      entry_t e;
      e = '{op: op, rnd: rnd, addr: addr, wdata: wdata, wstrb: wstrb, exp: exp};
      table_q.push_back(e);
      name_q.push_back(name);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////////////
   task automatic build_table();
      // Boot ROM reads and an ignored write
      add_entry("rom_rd_0", OP_READ_MEM, 1'b0, 32'h0000_0000, 32'h0, 4'h0, 32'h0);
      add_entry("rom_rd_5", OP_READ_MEM, 1'b0, 32'h0000_0014, 32'h0, 4'h0, 32'h0);
      add_entry("rom_rd_10", OP_READ_MEM, 1'b0, 32'h0000_0028, 32'h0, 4'h0, 32'h0);
      add_entry("rom_rd_15", OP_READ_MEM, 1'b0, 32'h0000_003c, 32'h0, 4'h0, 32'h0);
      add_entry("rom_wr_3", OP_WRITE, 1'b0, 32'h0000_000c, 32'hdead_beef, 4'hf, 32'h0);
      add_entry("rom_rd_3", OP_READ_MEM, 1'b0, 32'h0000_000c, 32'h0, 4'h0, 32'h0);
      // RAM full words then partial lanes
      add_entry("ram_wr_0", OP_WRITE, 1'b1, 32'h2000_0000, 32'h0, 4'hf, 32'h0);
      add_entry("ram_wr_1", OP_WRITE, 1'b1, 32'h2000_0004, 32'h0, 4'hf, 32'h0);
      add_entry("ram_wr_2", OP_WRITE, 1'b0, 32'h2000_0008, 32'h1122_3344, 4'hf, 32'h0);
      add_entry("ram_wr_3", OP_WRITE, 1'b1, 32'h2000_000c, 32'h0, 4'hf, 32'h0);
      add_entry("ram_wr_2_b0", OP_WRITE, 1'b0, 32'h2000_0008, 32'haaaa_aa55, 4'h1, 32'h0);
      add_entry("ram_wr_2_hi", OP_WRITE, 1'b1, 32'h2000_0008, 32'h0, 4'hc, 32'h0);
      add_entry("ram_wr_3_b1", OP_WRITE, 1'b0, 32'h2000_000c, 32'h0000_7e00, 4'h2, 32'h0);
      add_entry("ram_rd_0", OP_READ_MEM, 1'b0, 32'h2000_0000, 32'h0, 4'h0, 32'h0);
      add_entry("ram_rd_1", OP_READ_MEM, 1'b0, 32'h2000_0004, 32'h0, 4'h0, 32'h0);
      add_entry("ram_rd_2", OP_READ_MEM, 1'b0, 32'h2000_0008, 32'h0, 4'h0, 32'h0);
      add_entry("ram_rd_3", OP_READ_MEM, 1'b0, 32'h2000_000c, 32'h0, 4'h0, 32'h0);
      // Unmapped aliases of the soft-reset address and RAM word 1
      add_entry("umap_rd", OP_READ, 1'b0, 32'h8000_0000, 32'h0, 4'h0, 32'h0);
      add_entry("umap_rd_top", OP_READ, 1'b0, 32'hefff_fffc, 32'h0, 4'h0, 32'h0);
      add_entry("umap_wr", OP_WRITE, 1'b0, 32'ha000_0004, 32'h5555_aaaa, 4'hf, 32'h0);
      add_entry("ram_rd_1_again", OP_READ_MEM, 1'b0, 32'h2000_0004, 32'h0, 4'h0, 32'h0);
      // Soft reset and boot remap
      add_entry("sys_rd_pre", OP_READ, 1'b0, 32'h6000_0000, 32'h0, 4'h0, 32'h0);
      add_entry("soft_reset", OP_SOFT, 1'b0, SOFT_RESET_ADDR, 32'h0, 4'h0, 32'h0);
      add_entry("sys_rd_post", OP_READ, 1'b0, 32'h6000_0000, 32'h0, 4'h0, 32'h1);
      // Soft-reset address still reads zero with mem_sel set
      add_entry("soft_rd_again", OP_READ, 1'b0, SOFT_RESET_ADDR, 32'h0, 4'h0, 32'h0);
      add_entry("boot_rd_0", OP_READ_MEM, 1'b0, 32'h0000_0000, 32'h0, 4'h0, 32'h0);
      add_entry("boot_rd_1", OP_READ_MEM, 1'b0, 32'h0000_0004, 32'h0, 4'h0, 32'h0);
      add_entry("boot_rd_2", OP_READ_MEM, 1'b0, 32'h0000_0008, 32'h0, 4'h0, 32'h0);
      add_entry("boot_rd_3", OP_READ_MEM, 1'b0, 32'h0000_000c, 32'h0, 4'h0, 32'h0);
      // UART bytes in wdata[7:0] then wdata[15:8]
      add_entry("uart_data_rd", OP_READ, 1'b0, 32'h4000_0000, 32'h0, 4'h0, 32'h0);
      add_entry("uart_frames", OP_SERIAL, 1'b0, 32'h4000_0000, 32'h0000_3ca5, 4'h1, 32'h0);
      add_entry("uart_status", OP_READ, 1'b0, 32'h4000_0004, 32'h0, 4'h0, 32'h0);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////
   initial begin
      entry_t e;
      string  name;
      data_t  rdata;
      data_t  wdata;
      int     waited;
      int     soft_ready;
      int     first_ready;
      int     gap;

      reset        = 1'b1;
      req          = '0;
      remapped     = 1'b0;
      seed         = 32'h3b25_ac46;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      check_errors = 0;
      $readmemh("hw/boot_rom.hex", rom_img);
      build_table();

      // Outputs while reset is held
      repeat (RESET_CYCLES) @(negedge clk);
      check_value("reset ser_tx", 32'h1, data_t'(ser_tx));
      check_value("reset core_reset", 32'h0, data_t'(core_reset));
      check_value("reset mem_sel", 32'h0, data_t'(mem_sel));
      check_value("reset ready", 32'h0, data_t'(rsp.ready));
      check_value("reset sys_ready", 32'h0, data_t'(sys_ready));
      close_test("reset_state");

      // Power-on count after reset falls
      reset  = 1'b0;
      waited = 0;
      while (!sys_ready) begin
         @(negedge clk);
         waited++;
         if (waited > 4 * POR_CYCLES) begin
            abort_run("sys_ready never rose after reset");
         end
      end
      check_value("power_on", data_t'(POR_CYCLES), data_t'(waited));
      close_test("power_on");

      for (int i = 0; i < table_q.size(); i++) begin
         e     = table_q[i];
         name  = name_q[i];
         wdata = e.rnd ? $random(seed) : e.wdata;
         case (e.op)
            OP_READ: begin
               bus_access(e.addr, '0, '0, rdata);
               check_value(name, e.exp, rdata);
            end
            OP_READ_MEM: begin
               bus_access(e.addr, '0, '0, rdata);
               check_value(name, mem_expect(e.addr), rdata);
            end
            OP_WRITE: begin
               bus_access(e.addr, wdata, e.wstrb, rdata);
               check_value(name, 32'h0, rdata);
               shadow_write(e.addr, wdata, e.wstrb);
            end
            OP_SOFT: begin
               bus_access(e.addr, wdata, e.wstrb, rdata);
               soft_ready = ready_cycle;
               check_value(name, e.exp, rdata);
               remapped = 1'b1;
               waited   = 0;
               while (core_reset) begin
                  @(negedge clk);
                  waited++;
                  if (waited > 4 * SOFT_RESET_CYCLES) begin
                     abort_run("core_reset stuck high");
                  end
               end
               check_value("soft_reset width", data_t'(SOFT_RESET_CYCLES),
                           data_t'(core_hi_cnt));
               check_value("soft_reset start", data_t'(soft_ready + 1),
                           data_t'(core_first_hi));
               check_value("soft_reset mem_sel", 32'h1, data_t'(mem_sel));
            end
            default: begin
               // Decoder runs alongside the two writes and the status read
               fork
                  begin
                     serial_receive(rx_first);
                     serial_receive(rx_second);
                  end
                  begin
                     bus_access(e.addr, data_t'(e.wdata[7:0]), e.wstrb, rdata);
                     first_ready = ready_cycle;
                     bus_access(e.addr + 32'h4, '0, '0, rdata);
                     check_value("uart busy", 32'h1, rdata);
                     bus_access(e.addr, data_t'(e.wdata[15:8]), e.wstrb, rdata);
                     gap = ready_cycle - first_ready;
                  end
               join
               // Second ready only once the first frame is out
               assert (gap >= FRAME_BITS * BAUD_DIV) else begin
                  $display("[FAIL] %s expected at least %0d actual %0d", name,
                           FRAME_BITS * BAUD_DIV, gap);
                  test_errors++;
               end
               check_value("uart byte 0", data_t'(e.wdata[7:0]), data_t'(rx_first));
               check_value("uart byte 1", data_t'(e.wdata[15:8]), data_t'(rx_second));
               // Rest of the stop bit
               repeat (BAUD_DIV) @(negedge clk);
            end
         endcase
         close_test(name);
      end

      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, check_errors);
      if (tests_failed == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: hw/boot_rom.hex
// Boot image: one 32-bit word per line, in hex
// Lines are word index 0 to 15
b0000f00
b0010e11
b0020d22
b0030c33
b0040b44
b0050a55
b0060966
b0070877
b0080788
b0090699
b00a05aa
b00b04bb
b00c03cc
b00d02dd
b00e01ee
b00f00ff

// File: files.f
hw/soc_pkg.sv
hw/reset_ctrl.sv
hw/bus_interconnect.sv
hw/boot_rom.sv
hw/sram.sv
hw/uart_tx.sv
hw/soc_top.sv
verification/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module soc_tb -o soc_sim -f files.f &&
   ./obj_dir/soc_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null &&
   echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }
